/* Bender.yml */
package:
  name: packet_buffer

sources:
  - mem_types_pkg.sv
  - pkt_types_pkg.sv
  - slot_alloc.sv
  - packet_write.sv
  - packet_read.sv
  - mem_arbiter.sv
  - packet_mem.sv
  - packet_buffer.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_packet_buffer.sv

/* mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Memory arbiter: one access per cycle, alternating writer and reader
// --------------------------------------------------------------------
module mem_arbiter
    import mem_types_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     srst,
    input  wire mem_req_t wr_req,
    output logic          wr_gnt,
    input  wire mem_req_t rd_req,
    output logic          rd_gnt,
    output mem_req_t      mem_req
);
    logic rd_first;
    logic contested;

    assign contested = wr_req.req && rd_req.req;
    assign wr_gnt    = wr_req.req && !(contested && rd_first);
    assign rd_gnt    = rd_req.req && !wr_gnt;

    // Idle cycles pass the writer request, whose req is low then
    assign mem_req = rd_gnt ? rd_req : wr_req;

    // Loser of a contested cycle wins the next one
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_first <= 1'b0;
        end else if (contested) begin
            rd_first <= !rd_first;
        end
    end

endmodule
`default_nettype wire

/* mem_types_pkg.sv */
`default_nettype none
// --------------------------------------------------------------------
// Packet memory types: word address, data word and access request
// --------------------------------------------------------------------
package mem_types_pkg;

    typedef logic [6:0]  addr_t;
    typedef logic [63:0] mem_data_t;

    // One access per cycle, read when wr is low
    typedef struct packed {
        logic      req;
        logic      wr;
        addr_t     addr;
        mem_data_t data;
    } mem_req_t;

endpackage
`default_nettype wire

/* packet_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Packet buffer top: allocator, writer, reader, arbiter and memory
// --------------------------------------------------------------------
module packet_buffer
    import pkt_types_pkg::*, mem_types_pkg::*;
#(
    parameter int NUM_SLOTS     = 8,
    parameter int SLOT_WORDS    = 16,
    parameter int MIN_PKT_BYTES = 16,
    parameter bit DROP_ERRORED  = 1,
    parameter int MAX_CREDITS   = 4
) (
    input  wire logic      clk,
    input  wire logic      srst,
    input  wire pkt_word_t in_word,
    input  wire logic      in_vld,
    output logic           in_rdy,
    output pkt_word_t      out_word,
    output logic           out_vld,
    input  wire logic      credit_ret,
    output pkt_event_t     evt,
    output logic           evt_vld
);
    addr_t     slot_addr;
    logic      slot_vld;
    logic      slot_take;
    addr_t     free_addr;
    logic      free_vld;
    desc_t     desc;
    logic      desc_vld;
    mem_req_t  wr_req;
    logic      wr_gnt;
    mem_req_t  rd_req;
    logic      rd_gnt;
    mem_req_t  mem_req;
    mem_data_t rd_data;

    slot_alloc #(
        .NUM_SLOTS  (NUM_SLOTS),
        .SLOT_WORDS (SLOT_WORDS)
    ) u_slot_alloc (
        .clk       (clk),
        .srst      (srst),
        .slot_addr (slot_addr),
        .slot_vld  (slot_vld),
        .slot_take (slot_take),
        .free_addr (free_addr),
        .free_vld  (free_vld)
    );

    packet_write #(
        .SLOT_WORDS    (SLOT_WORDS),
        .MIN_PKT_BYTES (MIN_PKT_BYTES),
        .DROP_ERRORED  (DROP_ERRORED)
    ) u_packet_write (
        .clk       (clk),
        .srst      (srst),
        .in_word   (in_word),
        .in_vld    (in_vld),
        .in_rdy    (in_rdy),
        .slot_addr (slot_addr),
        .slot_vld  (slot_vld),
        .slot_take (slot_take),
        .mem_req   (wr_req),
        .mem_gnt   (wr_gnt),
        .desc      (desc),
        .desc_vld  (desc_vld),
        .evt       (evt),
        .evt_vld   (evt_vld)
    );

    packet_read #(
        .NUM_SLOTS   (NUM_SLOTS),
        .MAX_CREDITS (MAX_CREDITS)
    ) u_packet_read (
        .clk        (clk),
        .srst       (srst),
        .desc       (desc),
        .desc_vld   (desc_vld),
        .mem_req    (rd_req),
        .mem_gnt    (rd_gnt),
        .rd_data    (rd_data),
        .out_word   (out_word),
        .out_vld    (out_vld),
        .credit_ret (credit_ret),
        .free_addr  (free_addr),
        .free_vld   (free_vld)
    );

    mem_arbiter u_mem_arbiter (
        .clk     (clk),
        .srst    (srst),
        .wr_req  (wr_req),
        .wr_gnt  (wr_gnt),
        .rd_req  (rd_req),
        .rd_gnt  (rd_gnt),
        .mem_req (mem_req)
    );

    packet_mem u_packet_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (rd_data)
    );

endmodule
`default_nettype wire

/* packet_mem.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Single-port packet RAM with registered read data
// --------------------------------------------------------------------
module packet_mem
    import mem_types_pkg::*;
(
    input  wire logic     clk,
    input  wire mem_req_t mem_req,
    output mem_data_t     rd_data
);
    localparam int DEPTH = 2 ** $bits(addr_t);

    mem_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (mem_req.req) begin
            if (mem_req.wr) begin
                mem[mem_req.addr] <= mem_req.data;
            end else begin
                rd_data <= mem[mem_req.addr];
            end
        end
    end

endmodule
`default_nettype wire

/* packet_read.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Packet reader: queues descriptors, reads packets back from memory
// and sends them out under credit control
// --------------------------------------------------------------------
module packet_read
    import pkt_types_pkg::*, mem_types_pkg::*;
#(
    parameter int NUM_SLOTS   = 8,
    parameter int MAX_CREDITS = 4
) (
    input  wire logic      clk,
    input  wire logic      srst,
    input  wire desc_t     desc,
    input  wire logic      desc_vld,
    output mem_req_t       mem_req,
    input  wire logic      mem_gnt,
    input  wire mem_data_t rd_data,
    output pkt_word_t      out_word,
    output logic           out_vld,
    input  wire logic      credit_ret,
    output addr_t          free_addr,
    output logic           free_vld
);
    localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

    typedef logic [PTR_W-1:0]                 ptr_t;
    typedef logic [$clog2(NUM_SLOTS+1)-1:0]   q_cnt_t;
    typedef logic [$clog2(MAX_CREDITS+1)-1:0] credit_t;

    // Framing of the word that returns from memory next cycle
    typedef struct packed {
        logic  sop;
        logic  eop;
        mty_t  mty;
        meta_t meta;
    } rd_tag_t;

    desc_t   q_mem [NUM_SLOTS];
    ptr_t    q_wr_ptr;
    ptr_t    q_rd_ptr;
    q_cnt_t  q_cnt;
    desc_t   head;
    credit_t credits;
    addr_t   word_idx;
    logic    rd_fire;
    logic    rd_last;
    mty_t    last_mty;
    logic    rd_vld;
    rd_tag_t tag;

    function automatic ptr_t ptr_next(input ptr_t p);
        return (p == ptr_t'(NUM_SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head     = q_mem[q_rd_ptr];
    assign rd_last  = size_t'((word_idx + 1'b1) * DATA_BYTES) >= head.size;
    // Full last word wraps to zero
    assign last_mty = mty_t'(DATA_BYTES - head.size % DATA_BYTES);

    assign mem_req = '{
        req:  (q_cnt != '0) && (credits != '0),
        wr:   1'b0,
        addr: head.addr + word_idx,
        data: '0
    };
    assign rd_fire = mem_req.req && mem_gnt;

    // Slot goes back once its last word is read
    assign free_vld  = rd_fire && rd_last;
    assign free_addr = head.addr;

    always_ff @(posedge clk) begin
        if (srst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
            credits  <= credit_t'(MAX_CREDITS);
            word_idx <= '0;
            rd_vld   <= 1'b0;
        end else begin
            if (desc_vld) begin
                q_wr_ptr <= ptr_next(q_wr_ptr);
            end
            if (free_vld) begin
                q_rd_ptr <= ptr_next(q_rd_ptr);
            end
            q_cnt   <= q_cnt + q_cnt_t'(desc_vld) - q_cnt_t'(free_vld);
            credits <= credits + credit_t'(credit_ret) - credit_t'(rd_fire);
            if (rd_fire) begin
                word_idx <= rd_last ? '0 : word_idx + 1'b1;
            end
            rd_vld <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_vld) begin
            q_mem[q_wr_ptr] <= desc;
        end
        tag.sop  <= (word_idx == '0);
        tag.eop  <= rd_last;
        tag.mty  <= rd_last ? last_mty : '0;
        tag.meta <= head.meta;
    end

    assign out_vld  = rd_vld;
    assign out_word = '{
        data: rd_data,
        sop:  tag.sop,
        eop:  tag.eop,
        mty:  tag.mty,
        err:  1'b0,
        meta: tag.meta
    };

endmodule
`default_nettype wire

/* packet_write.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Packet writer: stores packets into slots, classifies each one and
// issues descriptors for good packets and an event for every packet
// --------------------------------------------------------------------
module packet_write
    import pkt_types_pkg::*, mem_types_pkg::*;
#(
    parameter int SLOT_WORDS    = 16,
    parameter int MIN_PKT_BYTES = 16,
    parameter bit DROP_ERRORED  = 1
) (
    input  wire logic      clk,
    input  wire logic      srst,
    input  wire pkt_word_t in_word,
    input  wire logic      in_vld,
    output logic           in_rdy,
    input  wire addr_t     slot_addr,
    input  wire logic      slot_vld,
    output logic           slot_take,
    output mem_req_t       mem_req,
    input  wire logic      mem_gnt,
    output desc_t          desc,
    output logic           desc_vld,
    output pkt_event_t     evt,
    output logic           evt_vld
);
    typedef logic [$bits(size_t)-1:0] word_cnt_t;
    typedef enum logic [1:0] {SOP, MOP, FLUSH} state_t;

    state_t    state;
    word_cnt_t word_cnt;
    logic      slot_held;
    logic      has_slot;
    logic      store;
    logic      accept;
    logic      last_fit;
    size_t     pkt_size;
    status_t   pkt_status;

    // --------------------------------------------------------------------
    // Input handshake and memory write
    // --------------------------------------------------------------------
    // Slot head does not move while held, so it doubles as the base
    assign has_slot = (state == SOP) ? slot_vld : slot_held;
    assign store    = has_slot && (state != FLUSH);

    // Stored words wait for a grant, dropped words are taken at once
    assign in_rdy   = store ? mem_gnt : in_vld;
    assign accept   = in_vld && in_rdy;
    assign last_fit = (word_cnt == word_cnt_t'(SLOT_WORDS - 1));

    assign mem_req = '{
        req:  in_vld && store,
        wr:   1'b1,
        addr: slot_addr + addr_t'(word_cnt),
        data: in_word.data
    };

    // --------------------------------------------------------------------
    // Classification at eop
    // --------------------------------------------------------------------
    always_comb begin
        pkt_size = size_t'((word_cnt + 1'b1) * DATA_BYTES) - size_t'(in_word.mty);
        // err is taken from the eop word
        if (DROP_ERRORED && in_word.err) begin
            pkt_status = ERR;
        end else if (!has_slot) begin
            pkt_status = OFLOW;
        end else if (state == FLUSH) begin
            pkt_status = LONG;
        end else if (pkt_size < size_t'(MIN_PKT_BYTES)) begin
            pkt_status = SHORT;
        end else begin
            pkt_status = OK;
        end
    end

    assign evt_vld   = accept && in_word.eop;
    assign evt       = '{size: pkt_size, status: pkt_status};
    assign desc_vld  = evt_vld && (pkt_status == OK);
    assign desc      = '{addr: slot_addr, size: pkt_size, meta: in_word.meta};
    // Dropped packets leave their slot at the allocator head for reuse
    assign slot_take = desc_vld;

    // --------------------------------------------------------------------
    // FSM and word count
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= SOP;
            word_cnt  <= '0;
            slot_held <= 1'b0;
        end else if (accept) begin
            if (in_word.eop) begin
                state    <= SOP;
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
                if (state == SOP) begin
                    state     <= MOP;
                    slot_held <= slot_vld;
                end else if ((state == MOP) && last_fit) begin
                    // Slot is full and more is coming
                    state <= FLUSH;
                end
            end
        end
    end

endmodule
`default_nettype wire

/* pkt_types_pkg.sv */
`default_nettype none
// --------------------------------------------------------------------
// Packet types: data words, descriptors and per-packet fate reporting
// --------------------------------------------------------------------
package pkt_types_pkg;
    import mem_types_pkg::*;

    localparam int DATA_BYTES = 8;

    typedef logic [8*DATA_BYTES-1:0] data_t;
    typedef logic [2:0]              mty_t;
    typedef logic [7:0]              meta_t;
    typedef logic [11:0]             size_t;

    // Fate of a finished input packet
    typedef enum logic [2:0] {
        OK    = 3'd0,
        ERR   = 3'd1,
        SHORT = 3'd2,
        LONG  = 3'd3,
        OFLOW = 3'd4
    } status_t;

    typedef struct packed {
        data_t data;
        logic  sop;
        logic  eop;
        mty_t  mty;   // empty bytes, valid on eop only
        logic  err;
        meta_t meta;
    } pkt_word_t;

    typedef struct packed {
        addr_t addr;  // slot base
        size_t size;
        meta_t meta;
    } desc_t;

    typedef struct packed {
        size_t   size;
        status_t status;
    } pkt_event_t;

endpackage
`default_nettype wire

/* slot_alloc.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Slot allocator: free list of slot base addresses
// --------------------------------------------------------------------
module slot_alloc
    import mem_types_pkg::*;
#(
    parameter int NUM_SLOTS  = 8,
    parameter int SLOT_WORDS = 16
) (
    input  wire logic  clk,
    input  wire logic  srst,
    output addr_t      slot_addr,
    output logic       slot_vld,
    input  wire logic  slot_take,
    input  wire addr_t free_addr,
    input  wire logic  free_vld
);
    localparam int PTR_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;

    typedef logic [PTR_W-1:0]               ptr_t;
    typedef logic [$clog2(NUM_SLOTS+1)-1:0] cnt_t;
    typedef enum logic {FILL, RUN} state_t;

    state_t state;
    addr_t  fifo_mem [NUM_SLOTS];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    cnt_t   count;
    addr_t  fill_addr;
    logic   push;
    logic   pop;
    addr_t  push_addr;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(NUM_SLOTS - 1)) ? '0 : p + 1'b1;
    endfunction

    // No packet can finish during FILL, so no release competes with it
    assign push      = (state == FILL) || free_vld;
    assign push_addr = (state == FILL) ? fill_addr : free_addr;
    assign pop       = slot_take && (count != '0);

    // Head stays put until taken, pushes land at the tail
    assign slot_addr = fifo_mem[rd_ptr];
    assign slot_vld  = (count != '0);

    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= FILL;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            fill_addr <= '0;
        end else begin
            if (state == FILL) begin
                fill_addr <= fill_addr + addr_t'(SLOT_WORDS);
                if (wr_ptr == ptr_t'(NUM_SLOTS - 1)) begin
                    state <= RUN;
                end
            end
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_addr;
        end
    end

endmodule
`default_nettype wire

/* tb.f */
mem_types_pkg.sv
pkt_types_pkg.sv
slot_alloc.sv
packet_write.sv
packet_read.sv
mem_arbiter.sv
packet_mem.sv
packet_buffer.sv
tb_checker.sv
tb_packet_buffer.sv

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Packet buffer checker comparing events and output packets with
// the expected queues and watching the output credit limit
// --------------------------------------------------------------------
module tb_checker
    import pkt_types_pkg::*;
#(
    parameter int MAX_CREDITS = 4
) (
    input  wire logic       clk,
    input  wire logic       srst,
    input  wire pkt_word_t  out_word,
    input  wire logic       out_vld,
    input  wire pkt_event_t evt,
    input  wire logic       evt_vld,
    input  wire logic       credit_ret
);
    // Expected words and events pushed by the stimulus
    pkt_word_t  exp_words [$];
    pkt_event_t exp_evts [$];

    int errors      = 0;
    int credit_errs = 0;
    int pkts_out    = 0;
    int out_cnt     = 0;
    int ret_cnt     = 0;

    pkt_word_t  exp_w;
    pkt_event_t exp_e;

    always @(posedge clk) begin
        if (!srst) begin
            if (evt_vld) begin
                if (exp_evts.size() == 0) begin
                    $display("FAIL %0t: event size %0d %s with none expected",
                             $time, evt.size, evt.status.name());
                    errors++;
                end else begin
                    exp_e = exp_evts.pop_front();
                    if (evt !== exp_e) begin
                        $display("FAIL %0t: event size %0d %s, expected %0d %s", $time,
                                 evt.size, evt.status.name(), exp_e.size, exp_e.status.name());
                        errors++;
                    end
                end
            end

            if (out_vld) begin
                if (exp_words.size() == 0) begin
                    $display("FAIL %0t: output word %h with no packet expected",
                             $time, out_word.data);
                    errors++;
                end else begin
                    exp_w = exp_words.pop_front();
                    if (out_word !== exp_w) begin
                        $display("FAIL %0t: out word %h %b %b %0d %h, expected %h %b %b %0d %h",
                                 $time, out_word.data, out_word.sop, out_word.eop,
                                 out_word.mty, out_word.meta, exp_w.data, exp_w.sop,
                                 exp_w.eop, exp_w.mty, exp_w.meta);
                        errors++;
                    end
                end
                if (out_word.eop) begin
                    pkts_out++;
                end
            end

            // Output words may never run ahead of the credits granted
            out_cnt += int'(out_vld);
            ret_cnt += int'(credit_ret);
            if (out_cnt > MAX_CREDITS + ret_cnt) begin
                $display("FAIL %0t: %0d words out with only %0d credits", $time,
                         out_cnt, MAX_CREDITS + ret_cnt);
                errors++;
                credit_errs++;
            end
        end
    end

endmodule
`default_nettype wire

/* tb_packet_buffer.sv */
`timescale 1ns/1ps
`default_nettype none
// --------------------------------------------------------------------
// Packet buffer testbench driving seeded random packets and credit
// returns and sequencing the tests around the DUT and the checker
// --------------------------------------------------------------------
module tb_packet_buffer
    import pkt_types_pkg::*;
();
    localparam int NUM_SLOTS     = 8;
    localparam int SLOT_WORDS    = 16;
    localparam int MIN_PKT_BYTES = 16;
    localparam int MAX_CREDITS   = 4;
    localparam int MAX_BYTES     = SLOT_WORDS * DATA_BYTES;
    localparam int RDY_TIMEOUT   = 1000;
    localparam int DRAIN_TIMEOUT = 5000;

    logic       clk = 1'b0;
    logic       srst;
    pkt_word_t  in_word;
    logic       in_vld;
    logic       in_rdy;
    pkt_word_t  out_word;
    logic       out_vld;
    logic       credit_ret;
    pkt_event_t evt;
    logic       evt_vld;

    int   seed = 32'heac4_4214;
    int   ok_sent = 0;
    int   owed = 0;
    bit   credits_on = 1'b1;
    bit   ret_coin;
    bit   hung = 1'b0;
    int   errs_start;
    int   total_errs;
    int   i;

    always #4 clk = ~clk;

    packet_buffer #(
        .NUM_SLOTS     (NUM_SLOTS),
        .SLOT_WORDS    (SLOT_WORDS),
        .MIN_PKT_BYTES (MIN_PKT_BYTES),
        .DROP_ERRORED  (1'b1),
        .MAX_CREDITS   (MAX_CREDITS)
    ) UUT (
        .clk        (clk),
        .srst       (srst),
        .in_word    (in_word),
        .in_vld     (in_vld),
        .in_rdy     (in_rdy),
        .out_word   (out_word),
        .out_vld    (out_vld),
        .credit_ret (credit_ret),
        .evt        (evt),
        .evt_vld    (evt_vld)
    );

    tb_checker #(
        .MAX_CREDITS (MAX_CREDITS)
    ) u_checker (
        .clk        (clk),
        .srst       (srst),
        .out_word   (out_word),
        .out_vld    (out_vld),
        .evt        (evt),
        .evt_vld    (evt_vld),
        .credit_ret (credit_ret)
    );

    // --------------------------------------------------------------------
    // Credit return of one pulse per received word at a random pace
    // --------------------------------------------------------------------
    always @(posedge clk) begin
        ret_coin = ($random(seed) & 1) != 0;
        #1;
        if (srst) begin
            owed       = 0;
            credit_ret = 1'b0;
        end else begin
            if (out_vld) begin
                owed++;
            end
            if (credits_on && (owed > 0) && ret_coin) begin
                credit_ret = 1'b1;
                owed--;
            end else begin
                credit_ret = 1'b0;
            end
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // --------------------------------------------------------------------
    // Stimulus tasks entered and left 1 ns after a rising edge
    // --------------------------------------------------------------------
    task automatic drive_word(input pkt_word_t w);
        int wait_cnt;
        wait_cnt = 0;
        in_word  = w;
        in_vld   = 1'b1;
        // in_rdy is combinational and settled by mid-cycle
        #2;
        while (!in_rdy && wait_cnt < RDY_TIMEOUT) begin
            @(posedge clk);
            #3;
            wait_cnt++;
        end
        if (!in_rdy) begin
            $display("Timeout: DUT input never became ready at %0t", $time);
            hung = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_packet(input int nbytes, input logic err, input status_t st);
        int         nwords;
        int         w_idx;
        int         gap;
        mty_t       mty;
        meta_t      meta;
        pkt_word_t  w;
        pkt_event_t e;
        if (hung) begin
            return;
        end
        nwords   = (nbytes + DATA_BYTES - 1) / DATA_BYTES;
        mty      = mty_t'(nwords * DATA_BYTES - nbytes);
        meta     = meta_t'($random(seed));
        e.size   = size_t'(nbytes);
        e.status = st;
        u_checker.exp_evts.push_back(e);
        if (st == OK) begin
            ok_sent++;
        end
        for (w_idx = 0; w_idx < nwords && !hung; w_idx++) begin
            w.data = {$random(seed), $random(seed)};
            w.sop  = (w_idx == 0);
            w.eop  = (w_idx == nwords - 1);
            w.mty  = w.eop ? mty : '0;
            w.err  = err;
            w.meta = meta;
            if (st == OK) begin
                u_checker.exp_words.push_back(w);
            end
            drive_word(w);
        end
        in_vld = 1'b0;
        gap = rand_range(0, 2);
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Keeps a free slot for the next packet
    task automatic wait_slot_free();
        int wait_cnt;
        wait_cnt = 0;
        if (hung) begin
            return;
        end
        while ((ok_sent - u_checker.pkts_out) >= NUM_SLOTS && wait_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if ((ok_sent - u_checker.pkts_out) >= NUM_SLOTS) begin
            $display("Timeout: no packet left the buffer to free a slot");
            hung = 1'b1;
        end
    endtask

    task automatic wait_drain();
        int  wait_cnt;
        wait_cnt = 0;
        if (hung) begin
            return;
        end
        while ((u_checker.exp_words.size() != 0 || u_checker.exp_evts.size() != 0 ||
                owed != 0) && wait_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (u_checker.exp_words.size() != 0 || u_checker.exp_evts.size() != 0 || owed != 0) begin
            $display("Timeout: %0d words and %0d events still expected",
                     u_checker.exp_words.size(), u_checker.exp_evts.size());
            hung = 1'b1;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (hung) begin
            $display("Test %0d %s: stopped by a timeout", num, name);
        end else begin
            $display("Test %0d %s: %0d errors", num, name, u_checker.errors - errs_start);
        end
    endtask

    // --------------------------------------------------------------------
    // Test sequence
    // --------------------------------------------------------------------
    initial begin
        srst       = 1'b1;
        in_vld     = 1'b0;
        in_word    = '0;
        credit_ret = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        srst = 1'b0;
        // Free list fill
        repeat (2 * NUM_SLOTS) @(posedge clk);
        #1;

        errs_start = u_checker.errors;
        for (i = 0; i < 20; i++) begin
            wait_slot_free();
            send_packet(rand_range(MIN_PKT_BYTES, MAX_BYTES), 1'b0, OK);
        end
        wait_drain();
        report_test(1, "random OK packets");

        errs_start = u_checker.errors;
        for (i = 0; i < 12; i++) begin
            wait_slot_free();
            case (i % 3)
                0:       send_packet(rand_range(MIN_PKT_BYTES, MAX_BYTES), 1'b1, ERR);
                1:       send_packet(rand_range(1, MIN_PKT_BYTES - 1), 1'b0, SHORT);
                default: send_packet(rand_range(MIN_PKT_BYTES, MAX_BYTES), 1'b0, OK);
            endcase
        end
        wait_drain();
        report_test(2, "errored and short packets");

        errs_start = u_checker.errors;
        for (i = 0; i < 8; i++) begin
            wait_slot_free();
            if (i % 2 == 0) begin
                send_packet(rand_range(MAX_BYTES + 1, MAX_BYTES + 72), 1'b0, LONG);
            end else begin
                send_packet(rand_range(MIN_PKT_BYTES, MAX_BYTES), 1'b0, OK);
            end
        end
        wait_drain();
        report_test(3, "long packets");

        // Over 4 words each, so the stalled reader frees no slot
        errs_start = u_checker.errors;
        credits_on = 1'b0;
        for (i = 0; i < 10; i++) begin
            send_packet(rand_range(40, MAX_BYTES), 1'b0, (i < NUM_SLOTS) ? OK : OFLOW);
        end
        credits_on = 1'b1;
        wait_drain();
        report_test(4, "slot overflow under credit stall");

        $display("Test 5 credit limit: %0d errors", u_checker.credit_errs);

        total_errs = u_checker.errors + int'(hung);
        $display("Summary: %0d OK packets sent, %0d packets out, %0d errors",
                 ok_sent, u_checker.pkts_out, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
`default_nettype wire
